//--- hdl/irig_b.sv
module irig_b import irig_b_pkg::*; #(
	parameter int BIT_CYCLES = 1250000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] ex_sig_b_code,
	output irig_time_t  time_out,
	output logic        time_valid,
	output logic        frame_error,
	output logic        locked
);

	logic sample_tick;
	irig_bit_wr_t bit_wr;
	logic frame_done;

	irig_b_bit_timer #(
		.BIT_CYCLES(BIT_CYCLES)
	) bit_timer_i (
		.clk(clk),
		.rst_n(rst_n),
		.sample_tick(sample_tick)
	);

	irig_b_frame_fsm frame_fsm_i (
		.clk(clk),
		.rst_n(rst_n),
		.sample_tick(sample_tick),
		.symbol(ex_sig_b_code),
		.bit_wr(bit_wr),
		.frame_done(frame_done),
		.frame_error(frame_error),
		.locked(locked)
	);

	irig_b_time_assembler time_assembler_i (
		.clk(clk),
		.rst_n(rst_n),
		.bit_wr(bit_wr),
		.frame_done(frame_done),
		.time_out(time_out),
		.time_valid(time_valid)
	);

endmodule

//--- hdl/irig_b_bit_timer.sv
module irig_b_bit_timer #(
	parameter int BIT_CYCLES = 1250000
) (
	input  logic clk,
	input  logic rst_n,
	output logic sample_tick
);

	localparam int CNT_W = $clog2(BIT_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CYCLES - 1);
	localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(BIT_CYCLES / 2 - 1);

	logic [CNT_W-1:0] cnt;

	// free running over one bit period
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// sample mid period away from symbol edges
	assign sample_tick = (cnt == CNT_MID);

endmodule

//--- hdl/irig_b_frame_fsm.sv
module irig_b_frame_fsm import irig_b_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         sample_tick,
	input  logic [31:0]  symbol,
	output irig_bit_wr_t bit_wr,
	output logic         frame_done,
	output logic         frame_error,
	output logic         locked
);

	localparam int SLOT_W = $clog2(MARK_PERIOD);
	localparam logic [SLOT_W-1:0] SLOT_MARK = SLOT_W'(MARK_PERIOD - 1);
	localparam logic [POS_W-1:0] POS_LAST = POS_W'(FRAME_LEN - 1);

	typedef enum logic [1:0] {
		SEARCH,
		SEEN_MARK,
		FRAME,
		AWAIT_REF
	} state_e;

	state_e state;
	irig_symbol_e sym;
	logic [POS_W-1:0] pos;
	logic [SLOT_W-1:0] slot; // pos modulo MARK_PERIOD

	always_comb begin
		case (symbol)
			CHAR_MARK: sym = SYM_MARK;
			CHAR_ZERO: sym = SYM_ZERO;
			CHAR_ONE:  sym = SYM_ONE;
			default:   sym = SYM_BAD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SEARCH;
			pos <= '0;
			slot <= '0;
			bit_wr <= '0;
			frame_done <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			bit_wr.en <= 1'b0;
			frame_done <= 1'b0;
			frame_error <= 1'b0;
			if (sample_tick) begin
				case (state)
					SEARCH: if (sym == SYM_MARK) state <= SEEN_MARK;
					SEEN_MARK, AWAIT_REF: begin
						if (sym == SYM_MARK) begin // reference marker at position 0
							state <= FRAME;
							pos <= POS_W'(1);
							slot <= SLOT_W'(1);
						end else begin
							state <= SEARCH;
							frame_error <= (state == AWAIT_REF);
						end
					end
					FRAME: begin
						if (sym == SYM_BAD) begin
							state <= SEARCH;
							frame_error <= 1'b1;
						end else if (slot == SLOT_MARK) begin
							if (sym != SYM_MARK) begin
								state <= SEARCH;
								frame_error <= 1'b1;
							end else if (pos == POS_LAST) begin
								state <= AWAIT_REF;
								frame_done <= 1'b1;
							end else begin
								pos <= pos + 1'b1;
								slot <= '0;
							end
						end else if (sym == SYM_MARK) begin
							// in a run of markers the last one is the reference
							if (pos != POS_W'(1)) begin
								state <= SEARCH;
								frame_error <= 1'b1;
							end
						end else begin
							bit_wr.en <= 1'b1;
							bit_wr.index <= pos;
							bit_wr.value <= (sym == SYM_ONE);
							pos <= pos + 1'b1;
							slot <= slot + 1'b1;
						end
					end
					default: state <= SEARCH;
				endcase
			end
		end
	end

	assign locked = (state == FRAME) || (state == AWAIT_REF);

endmodule

//--- hdl/irig_b_pkg.sv
package irig_b_pkg;

	`include "irig_b_defs.svh"

	typedef enum logic [1:0] {
		SYM_ZERO,
		SYM_ONE,
		SYM_MARK,
		SYM_BAD
	} irig_symbol_e;

	// decoded time as BCD digits with seconds at the low end
	typedef struct packed {
		logic [3:0] year_tens;
		logic [3:0] year_units;
		logic       fill_d;
		logic [1:0] day_hunds;
		logic [3:0] day_tens;
		logic [3:0] day_units;
		logic [1:0] fill_h;
		logic [1:0] hour_tens;
		logic [3:0] hour_units;
		logic       fill_m;
		logic [2:0] min_tens;
		logic [3:0] min_units;
		logic       fill_s;
		logic [2:0] sec_tens;
		logic [3:0] sec_units;
	} irig_time_t;

	// position 99 first, so each field's lsb lands on its lowest position
	typedef struct packed {
		logic [40:0] rsv_99_59;
		logic [3:0]  year_tens;    // 58..55
		logic        rsv_54;
		logic [3:0]  year_units;   // 53..50
		logic [7:0]  rsv_49_42;
		logic [1:0]  day_hunds;    // 41..40
		logic        rsv_39;
		logic [3:0]  day_tens;     // 38..35
		logic        rsv_34;
		logic [3:0]  day_units;    // 33..30
		logic [2:0]  rsv_29_27;
		logic [1:0]  hour_tens;    // 26..25
		logic        rsv_24;
		logic [3:0]  hour_units;   // 23..20
		logic [1:0]  rsv_19_18;
		logic [2:0]  min_tens;     // 17..15
		logic        rsv_14;
		logic [3:0]  min_units;    // 13..10
		logic        rsv_9;
		logic [2:0]  sec_tens;     // 8..6
		logic        rsv_5;
		logic [3:0]  sec_units;    // 4..1
		logic        rsv_0;
	} irig_frame_fields_t;

	typedef union packed {
		logic [FRAME_LEN-1:0] raw;
		irig_frame_fields_t   fields;
	} irig_frame_word_u;

	typedef struct packed {
		logic             en;
		logic [POS_W-1:0] index;
		logic             value;
	} irig_bit_wr_t;

endpackage

//--- hdl/irig_b_time_assembler.sv
module irig_b_time_assembler import irig_b_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  irig_bit_wr_t bit_wr,
	input  logic         frame_done,
	output irig_time_t   time_out,
	output logic         time_valid
);

	irig_frame_word_u frame_q;
	irig_time_t frame_time;

	// bit store written by frame position
	always_ff @(posedge clk) begin
		if (bit_wr.en) begin
			frame_q.raw[bit_wr.index] <= bit_wr.value;
		end
	end

	always_comb begin
		frame_time = '0;
		frame_time.sec_units = frame_q.fields.sec_units;
		frame_time.sec_tens = frame_q.fields.sec_tens;
		frame_time.min_units = frame_q.fields.min_units;
		frame_time.min_tens = frame_q.fields.min_tens;
		frame_time.hour_units = frame_q.fields.hour_units;
		frame_time.hour_tens = frame_q.fields.hour_tens;
		frame_time.day_units = frame_q.fields.day_units;
		frame_time.day_tens = frame_q.fields.day_tens;
		frame_time.day_hunds = frame_q.fields.day_hunds;
		frame_time.year_units = frame_q.fields.year_units;
		frame_time.year_tens = frame_q.fields.year_tens;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			time_out <= '0;
			time_valid <= 1'b0;
		end else begin
			time_valid <= frame_done;
			if (frame_done) begin
				time_out <= frame_time; // held until the next good frame
			end
		end
	end

endmodule

//--- include/irig_b_defs.svh
`ifndef IRIG_B_DEFS_SVH
`define IRIG_B_DEFS_SVH

// character codes on the line
localparam logic [31:0] CHAR_MARK = 32'd80; // "P"
localparam logic [31:0] CHAR_ZERO = 32'd48; // "0"
localparam logic [31:0] CHAR_ONE  = 32'd49; // "1"

// frame geometry
localparam int FRAME_LEN = 100;

// markers sit at every position that is MARK_PERIOD-1 modulo MARK_PERIOD
localparam int MARK_PERIOD = 10;

// width of a position index within the frame
localparam int POS_W = $clog2(FRAME_LEN);

`endif

//--- project.f
+incdir+include
hdl/irig_b_pkg.sv
hdl/irig_b_bit_timer.sv
hdl/irig_b_frame_fsm.sv
hdl/irig_b_time_assembler.sv
hdl/irig_b.sv
verif/irig_b_checker.sv
verif/tb_irig_b.sv

//--- verif/irig_b_checker.sv
module irig_b_checker import irig_b_pkg::*; #(
	parameter int BIT_CYCLES = 1250000
) (
	input  logic            clk,
	input  irig_time_t      time_out,
	input  logic            time_valid,
	input  logic            frame_error,
	input  logic            locked,
	input  int              req_seq,
	input  logic [8*16-1:0] exp_name,
	input  logic            exp_idle,
	input  logic            exp_good,
	input  irig_time_t      exp_time,
	output int              done_seq,
	output int              pass_count,
	output int              fail_count
);

	localparam int RESULT_WAIT = 120 * BIT_CYCLES;

	logic [8*16-1:0] cur_name;
	irig_time_t cur_time;
	irig_time_t last_good; // time_out must hold this across a bad frame
	logic cur_idle;
	logic cur_good;
	logic armed = 1'b0;
	int cur_seq;
	int check_fails;
	int stray_count = 0;

	assign fail_count = check_fails + stray_count;

	function automatic string time_str(input irig_time_t t);
		return $sformatf("day %0d%0d%0d %0d%0d:%0d%0d:%0d%0d year %0d%0d",
			t.day_hunds, t.day_tens, t.day_units, t.hour_tens, t.hour_units,
			t.min_tens, t.min_units, t.sec_tens, t.sec_units, t.year_tens, t.year_units);
	endfunction

	task automatic report(input string msg);
		if (msg == "") begin
			$display("PASS %0s", cur_name);
			pass_count++;
		end else begin
			$display("FAIL %0t %0s: %0s", $time, cur_name, msg);
			check_fails++;
		end
	endtask

	// outputs stay quiet until the tb drops exp_idle
	task automatic check_idle;
		int cyc;
		string msg;
		cyc = 0;
		msg = "";
		while (exp_idle && cyc < RESULT_WAIT) begin
			if (msg == "" && (locked !== 1'b0 || time_valid !== 1'b0 ||
					frame_error !== 1'b0 || time_out !== '0)) begin
				msg = $sformatf("not idle: locked %b time_valid %b frame_error %b, %0s",
					locked, time_valid, frame_error, time_str(time_out));
			end
			@(negedge clk);
			cyc++;
		end
		if (exp_idle) begin
			$display("idle check of %0s never ended", cur_name);
			check_fails++;
		end else begin
			report(msg);
		end
	endtask

	task automatic check_frame;
		int cyc;
		bit seen_lock;
		bit lock_drop;
		string msg;
		cyc = 0;
		seen_lock = 1'b0;
		lock_drop = 1'b0;
		msg = "";
		while (!(time_valid || frame_error) && cyc < RESULT_WAIT) begin
			if (locked) seen_lock = 1'b1;
			else if (seen_lock) lock_drop = 1'b1;
			@(negedge clk);
			cyc++;
		end
		if (!(time_valid || frame_error)) begin
			$display("test %0s timed out: no time_valid or frame_error in %0d cycles",
				cur_name, RESULT_WAIT);
			check_fails++;
		end else if (cur_good) begin
			if (frame_error) msg = "frame_error on a good frame";
			else if (time_out !== cur_time)
				msg = $sformatf("time_out %0s, expected %0s", time_str(time_out),
					time_str(cur_time));
			else if (!locked || !seen_lock || lock_drop) msg = "locked not held through frame";
			report(msg);
			last_good = cur_time;
		end else begin
			if (time_valid) msg = "time_valid on a bad frame";
			else if (locked) msg = "locked still high after frame_error";
			else if (time_out !== last_good)
				msg = $sformatf("time_out %0s, expected %0s", time_str(time_out),
					time_str(last_good));
			report(msg);
		end
	endtask

	initial begin
		done_seq = 0;
		pass_count = 0;
		check_fails = 0;
		last_good = '0;
		forever begin
			@(negedge clk);
			if (req_seq != done_seq) begin
				cur_seq = req_seq;
				cur_name = exp_name;
				cur_idle = exp_idle;
				cur_good = exp_good;
				cur_time = exp_time;
				armed <= 1'b1;
				if (cur_idle) check_idle();
				else check_frame();
				armed <= 1'b0;
				done_seq = cur_seq;
			end
		end
	end

	// pulses that no test asked for
	always @(negedge clk) begin
		if (!armed && (time_valid || frame_error)) begin
			$display("FAIL %0t: time_valid or frame_error outside any test", $time);
			stray_count++;
		end
	end

endmodule

//--- verif/irig_b_input.txt
# name, symbols for positions 0..99 (P marker, 0, 1, _ for code 95), result OK or ERR
# OK digits: day_hunds day_tens day_units hour_tens hour_units min_tens min_units sec_tens sec_units year_tens year_units
good_ref P10100000P000001000P100000100P110001110P100000000P001000100P000000000P000000000P000000000P000000000P OK 1 7 3 2 1 1 0 0 5 2 4
good_next P01100000P000001000P100000100P110001110P100000000P001000100P101100010P000000000P000000000P000000000P OK 1 7 3 2 1 1 0 0 6 2 4
good_midnight P00000000P000000000P000000000P001001110P100000000P001000100P000000000P000000000P000000000P000000000P OK 1 7 4 0 0 0 0 0 0 2 4
err_mark39 P10100000P000001000P100000100P1100011100100000000P001000100P000000000P000000000P000000000P000000000P ERR
good_resync P00000110P101001000P000100000P101000010P000000000P111000000P000000000P000000000P000000000P000000000P OK 0 4 5 0 8 1 5 3 0 0 7
err_bad_sym P00000110P101001000P00_100000P101000010P000000000P111000000P000000000P000000000P000000000P000000000P ERR
err_mark_data P00000110P101001000P000100000P101P00010P000000000P111000000P000000000P000000000P000000000P000000000P ERR
good_max P10010101P100101010P110000100P011000110P110000000P100101001P000000000P000000000P000000000P000000000P OK 3 6 6 2 3 5 9 5 9 9 9

//--- verif/tb_irig_b.sv
module tb_irig_b import irig_b_pkg::*; ();

	localparam int BIT_CYCLES = 20;

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] ex_sig_b_code;
	irig_time_t time_out;
	logic time_valid;
	logic frame_error;
	logic locked;

	// expected result handed to the checker with each new req_seq
	int req_seq;
	logic [8*16-1:0] exp_name;
	logic exp_idle;
	logic exp_good;
	irig_time_t exp_time;
	int done_seq;
	int pass_count;
	int fail_count;

	int fd;
	int line_errors;
	bit timed_out;

	always #10 clk = ~clk;

	irig_b #(.BIT_CYCLES(BIT_CYCLES)) irig_b_i (.*);

	irig_b_checker #(.BIT_CYCLES(BIT_CYCLES)) checker_i (.*);

	function automatic logic [31:0] sym_code(input byte ch);
		case (ch)
			"P": sym_code = CHAR_MARK;
			"0": sym_code = CHAR_ZERO;
			"1": sym_code = CHAR_ONE;
			default: sym_code = 32'd95; // "_" in the file
		endcase
	endfunction

	// called 1 unit after a rising edge, returns 1 unit after the last edge
	task automatic send_symbol(input logic [31:0] code);
		ex_sig_b_code = code;
		repeat (BIT_CYCLES) @(posedge clk);
		#1;
	endtask

	task automatic send_frame(input string syms, input bit good);
		for (int i = 0; i < FRAME_LEN; i++) begin
			send_symbol(sym_code(syms.getc(i)));
		end
		if (!good) send_symbol(CHAR_MARK); // lets the receiver find sync again
	endtask

	task automatic run_file;
		string line;
		string syms;
		string result;
		logic [8*16-1:0] name;
		int d[11];
		int n;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %s %s %d %d %d %d %d %d %d %d %d %d %d", name, syms,
					result, d[0], d[1], d[2], d[3], d[4], d[5], d[6], d[7], d[8], d[9], d[10]);
				if (syms.len() != FRAME_LEN ||
						!((result == "OK" && n == 14) || result == "ERR")) begin
					$display("malformed line in the input file: %0s", line);
					line_errors++;
				end else begin
					exp_name = name;
					exp_good = (result == "OK");
					exp_time = '0;
					exp_time.day_hunds = 2'(d[0]);
					exp_time.day_tens = 4'(d[1]);
					exp_time.day_units = 4'(d[2]);
					exp_time.hour_tens = 2'(d[3]);
					exp_time.hour_units = 4'(d[4]);
					exp_time.min_tens = 3'(d[5]);
					exp_time.min_units = 4'(d[6]);
					exp_time.sec_tens = 3'(d[7]);
					exp_time.sec_units = 4'(d[8]);
					exp_time.year_tens = 4'(d[9]);
					exp_time.year_units = 4'(d[10]);
					req_seq++;
					send_frame(syms, exp_good);
				end
			end
		end
	endtask

	task automatic wait_checker;
		int cyc;
		cyc = 0;
		while (done_seq != req_seq && cyc < 200 * BIT_CYCLES) begin
			@(posedge clk);
			cyc++;
		end
		if (done_seq != req_seq) begin
			$display("timed out waiting for the checker to finish its last test");
			timed_out = 1'b1;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		ex_sig_b_code = '0;
		req_seq = 0;
		exp_name = "reset_idle";
		exp_idle = 1'b1;
		exp_good = 1'b0;
		exp_time = '0;
		line_errors = 0;
		timed_out = 1'b0;
		fd = $fopen("verif/irig_b_input.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/irig_b_input.txt");
			$display("SIMULATION FAILED");
		end else begin
			repeat (10) @(posedge clk);
			#1;
			rst_n = 1'b1;
			req_seq = 1; // idle window of invalid code 0
			repeat (10) send_symbol(32'd0);
			exp_idle = 1'b0;
			send_symbol(CHAR_MARK); // marker ahead of the first frame
			run_file();
			$fclose(fd);
			wait_checker();
			$display("tests passed %0d, failed %0d", pass_count, fail_count + line_errors);
			if (fail_count == 0 && line_errors == 0 && !timed_out && pass_count > 1) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
		end
		$finish;
	end

endmodule
